// ==== src/shift_pkg.sv ====
// shared constants and types for the 16-bit shifter; amount is 4 bits, so distances stop at 15
`default_nettype none

package shift_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int DATA_W     = 16;
  localparam int AMT_W      = 4;
  localparam int NUM_STAGES = 4;
  localparam int ADR_W      = 2;

  ////////////////////
  // register map
  ////////////////////

  localparam logic [ADR_W-1:0] ADDR_OPERAND = 2'd0;
  localparam logic [ADR_W-1:0] ADDR_CMD     = 2'd1;
  localparam logic [ADR_W-1:0] ADDR_RESULT  = 2'd2;

  // command word fields
  localparam int CMD_AMT_LSB = 0;
  localparam int CMD_OP_LSB  = 4;

  // shifts fill with zeros, rotates wrap
  typedef enum logic [1:0] {
    OP_SHL = 2'd0,
    OP_SHR = 2'd1,
    OP_ROL = 2'd2,
    OP_ROR = 2'd3
  } shift_op_e;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_ACK,
    BUS_WAIT_RESULT
  } bus_state_e;

endpackage

`default_nettype wire

// ==== src/shift_stage_if.sv ====
// one pipeline hop with no ready signal, so the receiver must take every valid beat
`timescale 1ns/1ps
`default_nettype none

interface shift_stage_if;
  import shift_pkg::*;

  logic              valid;
  logic [DATA_W-1:0] data;
  shift_op_e         op;
  logic [AMT_W-1:0]  amount;

  // receiving side
  modport up (
    input valid, data, op, amount
  );

  // sending side
  modport down (
    output valid, data, op, amount
  );

endinterface

`default_nettype wire

// ==== src/shift_stage.sv ====
// single registered step; DIST must be a power of two below DATA_W, latency is one cycle
`timescale 1ns/1ps
`default_nettype none

module shift_stage #(
  parameter int DIST = 1
) (
  input logic         clk,
  input logic         rst,
  shift_stage_if.up   prev,
  shift_stage_if.down next
);
  import shift_pkg::*;

  logic              hit;
  logic [DATA_W-1:0] moved;

  // amount bit that belongs to this distance
  assign hit = prev.amount[$clog2(DIST)];

  ////////////////////
  // move by DIST
  ////////////////////

  always_comb begin
    moved = prev.data;
    case (prev.op)
      OP_SHL: moved = prev.data << DIST;
      OP_SHR: moved = prev.data >> DIST;
      OP_ROL: moved = (prev.data << DIST) | (prev.data >> (DATA_W - DIST));
      OP_ROR: moved = (prev.data >> DIST) | (prev.data << (DATA_W - DIST));
      default: moved = prev.data;
    endcase
  end

  ////////////////////
  // pipeline register
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      next.valid <= 1'b0;
    end else begin
      next.valid <= prev.valid;
    end
  end

  // data, op and amount
  always_ff @(posedge clk) begin
    next.data   <= hit ? moved : prev.data;
    next.op     <= prev.op;
    next.amount <= prev.amount;
  end

endmodule

`default_nettype wire

// ==== src/shift_ctrl.sv ====
// Wishbone classic slave; master must hold cyc/stb until ack, RESULT reads stall while busy
`timescale 1ns/1ps
`default_nettype none

module shift_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [shift_pkg::ADR_W-1:0]  wb_adr,
  input  logic [shift_pkg::DATA_W-1:0] wb_dat_w,
  output logic [shift_pkg::DATA_W-1:0] wb_dat_r,
  output logic                        wb_ack,
  shift_stage_if.down                 issue,
  shift_stage_if.up                   done
);
  import shift_pkg::*;

  bus_state_e state;

  logic [DATA_W-1:0] operand;
  logic [DATA_W-1:0] result;
  logic [DATA_W-1:0] rd_data;

  // enough room for a full pipe plus one
  logic [$clog2(NUM_STAGES+1)-1:0] inflight;

  logic accept;
  logic wr_operand;
  logic wr_cmd;
  logic rd_result;

  ////////////////////
  // request decode
  ////////////////////

  // new request only counts in idle
  assign accept     = (state == BUS_IDLE) && wb_cyc && wb_stb;
  assign wr_operand = accept && wb_we && (wb_adr == ADDR_OPERAND);
  assign wr_cmd     = accept && wb_we && (wb_adr == ADDR_CMD);
  assign rd_result  = accept && !wb_we && (wb_adr == ADDR_RESULT);

  // CMD and unmapped word read back as zero
  always_comb begin
    rd_data = '0;
    if (wb_adr == ADDR_OPERAND) begin
      rd_data = operand;
    end
  end

  ////////////////////
  // bus FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= BUS_IDLE;
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
    end else begin
      wb_ack <= 1'b0;
      case (state)
        BUS_IDLE: begin
          if (rd_result) begin
            state <= BUS_WAIT_RESULT;
          end else if (accept) begin
            wb_ack   <= 1'b1;
            wb_dat_r <= rd_data;
            state    <= BUS_ACK;
          end
        end
        // ack high for this one cycle only
        BUS_ACK: begin
          state <= BUS_IDLE;
        end
        BUS_WAIT_RESULT: begin
          // hold off until the newest command has landed
          if (inflight == '0) begin
            wb_ack   <= 1'b1;
            wb_dat_r <= result;
            state    <= BUS_ACK;
          end
        end
        default: begin
          state <= BUS_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      operand <= '0;
    end else if (wr_operand) begin
      operand <= wb_dat_w;
    end
  end

  // last completed command
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (done.valid) begin
      result <= done.data;
    end
  end

  ////////////////////
  // issue and tracking
  ////////////////////

  // command enters the pipe on the ack cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= wr_cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_cmd) begin
      issue.data   <= operand;
      issue.amount <= wb_dat_w[CMD_AMT_LSB +: AMT_W];
      issue.op     <= shift_op_e'(wb_dat_w[CMD_OP_LSB +: $bits(shift_op_e)]);
    end
  end

  // issue and retire in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      inflight <= '0;
    end else if (wr_cmd && !done.valid) begin
      inflight <= inflight + 1'b1;
    end else if (!wr_cmd && done.valid) begin
      inflight <= inflight - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/shift_unit_top.sv ====
// four-stage pipelined shift/rotate unit; a command's result lands five cycles after its ack
`timescale 1ns/1ps
`default_nettype none

module shift_unit_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [shift_pkg::ADR_W-1:0]  wb_adr,
  input  logic [shift_pkg::DATA_W-1:0] wb_dat_w,
  output logic [shift_pkg::DATA_W-1:0] wb_dat_r,
  output logic                        wb_ack
);

  ////////////////////
  // stage links
  ////////////////////

  shift_stage_if link_issue ();
  shift_stage_if link_s8 ();
  shift_stage_if link_s4 ();
  shift_stage_if link_s2 ();
  shift_stage_if link_done ();

  shift_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .issue    (link_issue.down),
    .done     (link_done.up)
  );

  ////////////////////
  // pipeline
  ////////////////////

  // largest distance first
  shift_stage #(.DIST(8)) u_stage_8 (
    .clk  (clk),
    .rst  (rst),
    .prev (link_issue.up),
    .next (link_s8.down)
  );

  shift_stage #(.DIST(4)) u_stage_4 (
    .clk  (clk),
    .rst  (rst),
    .prev (link_s8.up),
    .next (link_s4.down)
  );

  shift_stage #(.DIST(2)) u_stage_2 (
    .clk  (clk),
    .rst  (rst),
    .prev (link_s4.up),
    .next (link_s2.down)
  );

  shift_stage #(.DIST(1)) u_stage_1 (
    .clk  (clk),
    .rst  (rst),
    .prev (link_s2.up),
    .next (link_done.down)
  );

endmodule

`default_nettype wire

// ==== test/shift_tests.svh ====
// directed tests; needs the bus tasks, model and counters of tb_shift_unit in scope
`ifndef SHIFT_TESTS_SVH
`define SHIFT_TESTS_SVH

////////////////////
// command helpers
////////////////////

task automatic issue_cmd(input shift_op_e op, input logic [DATA_W-1:0] x,
                         input logic [AMT_W-1:0] amt);
  wb_write(ADDR_OPERAND, x);
  wb_write(ADDR_CMD, cmd_word(op, amt));
endtask

task automatic check_op(input shift_op_e op, input logic [DATA_W-1:0] x,
                        input logic [AMT_W-1:0] amt);
  logic [DATA_W-1:0] got;
  issue_cmd(op, x, amt);
  wb_read(ADDR_RESULT, got);
  check_value($sformatf("wb_dat_r (%s %h by %0d)", op.name(), x, amt), got,
              model_result(op, x, amt));
endtask

// both fixed operands, every amount
task automatic sweep_amounts(input shift_op_e op);
  logic [DATA_W-1:0] x;
  for (int i = 0; i < 2; i++) begin
    x = (i == 0) ? 16'h8421 : 16'hF00F;
    for (int a = 0; a < 16; a++) begin
      check_op(op, x, a[AMT_W-1:0]);
    end
  end
endtask

////////////////////
// tests
////////////////////

task automatic test_reset_values();
  int                err0;
  logic [DATA_W-1:0] rd;
  err0 = errors;
  check_value("wb_ack", {{(DATA_W-1){1'b0}}, wb_ack}, '0);
  wb_read(ADDR_RESULT, rd);
  check_value("wb_dat_r (RESULT)", rd, '0);
  wb_read(ADDR_OPERAND, rd);
  check_value("wb_dat_r (OPERAND)", rd, '0);
  finish_test("reset_values", err0);
endtask

task automatic test_register_access();
  int                err0;
  logic [DATA_W-1:0] rd;
  err0 = errors;
  wb_write(ADDR_OPERAND, 16'hA5C3);
  wb_read(ADDR_OPERAND, rd);
  check_value("wb_dat_r (OPERAND)", rd, 16'hA5C3);
  // unmapped word ignores writes
  wb_write(2'd3, 16'hFFFF);
  wb_read(2'd3, rd);
  check_value("wb_dat_r (address 3)", rd, '0);
  wb_read(ADDR_OPERAND, rd);
  check_value("wb_dat_r (OPERAND)", rd, 16'hA5C3);
  wb_read(ADDR_CMD, rd);
  check_value("wb_dat_r (CMD)", rd, '0);
  finish_test("register_access", err0);
endtask

task automatic test_shifts();
  int err0;
  err0 = errors;
  sweep_amounts(OP_SHL);
  sweep_amounts(OP_SHR);
  finish_test("shifts", err0);
endtask

task automatic test_rotates();
  int                err0;
  logic [DATA_W-1:0] got;
  err0 = errors;
  sweep_amounts(OP_ROL);
  sweep_amounts(OP_ROR);
  // zero amount is identity
  issue_cmd(OP_ROL, 16'h8421, '0);
  wb_read(ADDR_RESULT, got);
  check_value("wb_dat_r (ROL by 0)", got, 16'h8421);
  issue_cmd(OP_ROR, 16'hF00F, '0);
  wb_read(ADDR_RESULT, got);
  check_value("wb_dat_r (ROR by 0)", got, 16'hF00F);
  finish_test("rotates", err0);
endtask

task automatic test_back_to_back();
  int                err0;
  logic [DATA_W-1:0] got;
  err0 = errors;
  issue_cmd(OP_SHL, 16'h1234, 4'd3);
  issue_cmd(OP_ROR, 16'h8001, 4'd5);
  issue_cmd(OP_SHR, 16'hBEEF, 4'd7);
  issue_cmd(OP_ROL, 16'h0F0F, 4'd9);
  // read stalls until the pipe drains
  wb_read(ADDR_RESULT, got);
  check_value("wb_dat_r (back to back)", got, model_result(OP_ROL, 16'h0F0F, 4'd9));
  finish_test("back_to_back", err0);
endtask

task automatic test_random();
  int          err0;
  logic [31:0] r;
  err0 = errors;
  for (int n = 0; n < 150; n++) begin
    r = $random(seed);
    check_op(shift_op_e'(r[21:20]), r[15:0], r[19:16]);
  end
  finish_test("random", err0);
endtask

`endif

// ==== test/tb_shift_unit.sv ====
// directed testbench for shift_unit_top; stimulus 1 ns after the rising edge, outputs sampled there too
`timescale 1ns/1ps
`default_nettype none

module tb_shift_unit;
  import shift_pkg::*;

  // about 280 commands at roughly ten cycles each, with margin
  localparam int TIMEOUT_CYCLES = 5000;

  logic              clk;
  logic              rst;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADR_W-1:0]  wb_adr;
  logic [DATA_W-1:0] wb_dat_w;
  logic [DATA_W-1:0] wb_dat_r;
  logic              wb_ack;

  int     errors;
  int     checks;
  int     tests_run;
  int     cycles;
  integer seed;

  shift_unit_top DUT (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: no finish after %0d cycles, a bus cycle never completed", cycles);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////
  // bus access
  ////////////////////

  // entered and left 1 ns after a rising edge
  task automatic wait_ack();
    do begin
      @(posedge clk);
      #1;
    end while (!wb_ack);
  endtask

  task automatic bus_idle();
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
  endtask

  task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack();
    bus_idle();
  endtask

  task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DATA_W-1:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack();
    data = wb_dat_r;
    bus_idle();
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // rotates taken from a doubled word
  function automatic logic [DATA_W-1:0] model_result(input shift_op_e op,
                                                     input logic [DATA_W-1:0] x,
                                                     input logic [AMT_W-1:0] amt);
    logic [2*DATA_W-1:0] both;
    both = {x, x};
    case (op)
      OP_SHL: return x << amt;
      OP_SHR: return x >> amt;
      OP_ROL: begin
        both = both << amt;
        return both[2*DATA_W-1:DATA_W];
      end
      default: begin
        both = both >> amt;
        return both[DATA_W-1:0];
      end
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] cmd_word(input shift_op_e op,
                                                 input logic [AMT_W-1:0] amt);
    logic [DATA_W-1:0] w;
    w = '0;
    w[CMD_AMT_LSB +: AMT_W] = amt;
    w[CMD_OP_LSB +: 2]      = op;
    return w;
  endfunction

  task automatic check_value(input string sig, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    checks = checks + 1;
    assert (got === exp) else begin
      $display("Error: %s = %h, expected %h", sig, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic finish_test(input string name, input int errors_at_start);
    tests_run = tests_run + 1;
    $display("test %s finished, %0d errors", name, errors - errors_at_start);
  endtask

  `include "shift_tests.svh"

  initial begin
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    cycles    = 0;
    seed      = 32'h5b1f7f7d;
    rst       = 1'b1;
    bus_idle();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset_values();
    test_register_access();
    test_shifts();
    test_rotates();
    test_back_to_back();
    test_random();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+test
src/shift_pkg.sv
src/shift_stage_if.sv
src/shift_stage.sv
src/shift_ctrl.sv
src/shift_unit_top.sv
test/tb_shift_unit.sv

// ==== Makefile ====
SRCS := $(wildcard src/*.sv) test/tb_shift_unit.sv test/shift_tests.svh all.f

.PHONY: all run clean

all: run

obj_dir/Vtb_shift_unit: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_shift_unit \
		-Mdir obj_dir -o Vtb_shift_unit

run: obj_dir/Vtb_shift_unit
	./obj_dir/Vtb_shift_unit | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
